// File: dcache_golden.txt
# op  word_addr  wdata     rdata     writeback  hit
# rdata is hex, mem for the memory's initial word, - for none; writeback is a line address or none
R 00000000 00000000 mem      none    miss
R 00000001 00000000 mem      none    hit
W 00000002 deadbeef -        none    hit
R 00000002 00000000 deadbeef none    hit
R 00000010 00000000 mem      none    miss
W 00000011 cafef00d -        none    hit
R 00000020 00000000 mem      0000000 miss
R 00000021 00000000 mem      none    hit
R 00000030 00000000 mem      0000004 miss
R 00000002 00000000 deadbeef none    miss
R 00000011 00000000 cafef00d none    miss
R 00000000 00000000 mem      none    hit
R 00000012 00000000 mem      none    hit
W 00000104 11111111 -        none    miss
R 00000104 00000000 11111111 none    hit
R 00000105 00000000 mem      none    hit
R 3ffffff4 00000000 mem      none    miss
R 00000204 00000000 mem      0000041 miss
R 00000104 00000000 11111111 none    miss
R 3ffffff7 00000000 mem      none    miss
W 00000008 aaaa5555 -        none    miss
W 00000009 bbbb6666 -        none    hit
R 00000008 00000000 aaaa5555 none    hit
R 0000000b 00000000 mem      none    hit

// File: dcache.f
+incdir+.
dcache_pkg.sv
cache_way.sv
way_select.sv
cache_ctrl.sv
dcache.sv
dcache_checker.sv
tb_dcache.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f dcache.f --top-module tb_dcache -o sim_dcache

./obj_dir/sim_dcache | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// File: tb_dcache.sv
// data cache testbench
`default_nettype none
`timescale 1ns/1ps

`include "dcache_settings.svh"

module tb_dcache;

	localparam logic [31:0] SEED         = 32'h55d93a5b;
	localparam int          MAX_TESTS    = 64;
	localparam int          RESET_CYCLES = 5;

	logic                   clk;
	logic                   proc_reset;
	logic                   proc_read;
	logic                   proc_write;
	dcache_pkg::proc_addr_t proc_addr;
	dcache_pkg::word_t      proc_wdata;
	dcache_pkg::word_t      proc_rdata;
	logic                   proc_stall;
	logic                   mem_read;
	logic                   mem_write;
	dcache_pkg::mem_addr_t  mem_addr;
	dcache_pkg::line_t      mem_wdata;
	dcache_pkg::line_t      mem_rdata;
	logic                   mem_ready;

	// expectations handed to the checker with each request
	int                    test_id;
	logic                  exp_hit;
	logic [1:0]            exp_rd_kind;
	dcache_pkg::word_t     exp_rdata;
	logic                  exp_wb_valid;
	dcache_pkg::mem_addr_t exp_wb_addr;
	int                    errors;
	int                    tests_done;

	// golden table
	logic                  g_write   [MAX_TESTS];
	logic [29:0]           g_addr    [MAX_TESTS];
	dcache_pkg::word_t     g_wdata   [MAX_TESTS];
	logic [1:0]            g_rd_kind [MAX_TESTS];
	dcache_pkg::word_t     g_rdata   [MAX_TESTS];
	logic                  g_wb      [MAX_TESTS];
	dcache_pkg::mem_addr_t g_wb_addr [MAX_TESTS];
	logic                  g_hit     [MAX_TESTS];
	int                    num_tests;
	logic                  loaded;

	// memory model
	dcache_pkg::line_t mem_lines [logic [27:0]];
	logic [31:0]       rng;
	int                lat;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic dcache_pkg::line_t fetch_line(input logic [27:0] la);
		dcache_pkg::line_t l;
		if (mem_lines.exists(la)) begin
			return mem_lines[la];
		end
		for (int k = 0; k < `DC_WORDS_PER_LINE; k++) begin
			l[k*`DC_WORD_BITS +: `DC_WORD_BITS] = xorshift32(SEED ^ {2'b00, la, 2'(k)});
		end
		return l;
	endfunction

	task automatic load_golden();
		int          fd;
		int          n;
		string       text;
		string       op;
		string       rd_s;
		string       wb_s;
		string       hm_s;
		logic [29:0] a;
		logic [31:0] wd;
		logic [31:0] v;
		logic [27:0] wb;
		num_tests = 0;
		fd = $fopen("dcache_golden.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				text = "";
				void'($fgets(text, fd));
				if (text.len() > 1 && text.substr(0, 0) != "#" && num_tests < MAX_TESTS) begin
					n = $sscanf(text, "%s %h %h %s %s %s", op, a, wd, rd_s, wb_s, hm_s);
					if (n == 6) begin
						g_write[num_tests]   = (op == "W");
						g_addr[num_tests]    = a;
						g_wdata[num_tests]   = wd;
						g_rd_kind[num_tests] = (rd_s == "-") ? 2'd0 : (rd_s == "mem") ? 2'd1 : 2'd2;
						v = '0;
						if (g_rd_kind[num_tests] == 2'd2) begin
							void'($sscanf(rd_s, "%h", v));
						end
						g_rdata[num_tests] = v;
						wb = '0;
						g_wb[num_tests] = (wb_s != "none");
						if (g_wb[num_tests]) begin
							void'($sscanf(wb_s, "%h", wb));
						end
						g_wb_addr[num_tests] = wb;
						g_hit[num_tests]     = (hm_s == "hit");
						num_tests++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic apply_request(input int i);
		test_id      <= i;
		proc_read    <= !g_write[i];
		proc_write   <= g_write[i];
		proc_addr    <= g_addr[i];
		proc_wdata   <= g_wdata[i];
		exp_hit      <= g_hit[i];
		exp_rd_kind  <= g_rd_kind[i];
		exp_rdata    <= g_rdata[i];
		exp_wb_valid <= g_wb[i];
		exp_wb_addr  <= g_wb_addr[i];
	endtask

	dcache dcache_inst (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	dcache_checker checker_inst (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_read    (proc_read),
		.proc_write   (proc_write),
		.proc_addr    (proc_addr),
		.proc_wdata   (proc_wdata),
		.proc_rdata   (proc_rdata),
		.proc_stall   (proc_stall),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.mem_ready    (mem_ready),
		.test_id      (test_id),
		.exp_hit      (exp_hit),
		.exp_rd_kind  (exp_rd_kind),
		.exp_rdata    (exp_rdata),
		.exp_wb_valid (exp_wb_valid),
		.exp_wb_addr  (exp_wb_addr),
		.errors       (errors),
		.tests_done   (tests_done)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------
	// memory with random latency
	// ------------------------------
	always @(posedge clk) begin
		if (proc_reset) begin
			mem_ready <= 1'b0;
			lat       <= 0;
		end else if (mem_ready) begin
			mem_ready <= 1'b0;    // finished strobe still visible on this edge
		end else if (mem_read || mem_write) begin
			if (lat == 0) begin
				rng = xorshift32(rng);
				lat <= 1 + int'(rng[1:0]);
			end else if (lat == 1) begin
				lat       <= 0;
				mem_ready <= 1'b1;
				if (mem_write) begin
					mem_lines[mem_addr] = mem_wdata;
				end else begin
					mem_rdata <= fetch_line(mem_addr);
				end
			end else begin
				lat <= lat - 1;
			end
		end
	end

	// watchdog, about 20 cycles per request
	initial begin
		wait (loaded);
		repeat (RESET_CYCLES + 3 + 20 * num_tests + 10) @(posedge clk);
		$display("timeout: requests did not complete in time");
		$display("TB FAILED");
		$finish;
	end

	initial begin
		proc_reset   = 1'b1;
		proc_read    = 1'b0;
		proc_write   = 1'b0;
		proc_addr    = '0;
		proc_wdata   = '0;
		mem_rdata    = '0;
		mem_ready    = 1'b0;
		lat          = 0;
		rng          = SEED;
		test_id      = 0;
		exp_hit      = 1'b0;
		exp_rd_kind  = 2'd0;
		exp_rdata    = '0;
		exp_wb_valid = 1'b0;
		exp_wb_addr  = '0;
		loaded       = 1'b0;
		load_golden();
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		proc_reset <= 1'b0;
		repeat (3) @(posedge clk);
		if (num_tests == 0) begin
			$display("no requests could be read from dcache_golden.txt");
		end
		for (int i = 0; i < num_tests; i++) begin
			apply_request(i);
			do begin
				@(posedge clk);
			end while (proc_stall);
		end
		proc_read  <= 1'b0;
		proc_write <= 1'b0;
		repeat (4) @(posedge clk);
		$display("tests %0d of %0d, errors %0d", tests_done, num_tests, errors);
		if (num_tests > 0 && errors == 0 && tests_done == num_tests) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dcache_checker.sv
// data cache response checker
`default_nettype none
`timescale 1ns/1ps

`include "dcache_settings.svh"

module dcache_checker (
	input  logic                   clk,
	input  logic                   proc_reset,
	input  logic                   proc_read,
	input  logic                   proc_write,
	input  dcache_pkg::proc_addr_t proc_addr,
	input  dcache_pkg::word_t      proc_wdata,
	input  dcache_pkg::word_t      proc_rdata,
	input  logic                   proc_stall,
	input  logic                   mem_read,
	input  logic                   mem_write,
	input  dcache_pkg::mem_addr_t  mem_addr,
	input  dcache_pkg::line_t      mem_wdata,
	input  logic                   mem_ready,
	// expectations for the request in flight
	input  int                     test_id,
	input  logic                   exp_hit,
	input  logic [1:0]             exp_rd_kind,    // 0 none, 1 memory word, 2 given value
	input  dcache_pkg::word_t      exp_rdata,
	input  logic                   exp_wb_valid,
	input  dcache_pkg::mem_addr_t  exp_wb_addr,
	output int                     errors,
	output int                     tests_done
);

	localparam logic [31:0] SEED = 32'h55d93a5b;

	dcache_pkg::word_t     shadow [logic [29:0]];    // words as the processor wrote them
	logic                  reset_seen;
	logic                  seen_stall;
	int                    wb_cnt;
	int                    test_errs;
	dcache_pkg::mem_addr_t wb_addr;
	logic                  prev_rd;
	logic                  prev_wr;
	logic                  prev_ready;
	dcache_pkg::mem_addr_t prev_addr;
	dcache_pkg::line_t     prev_wdata;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic dcache_pkg::word_t word_value(input logic [29:0] a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return xorshift32(SEED ^ {2'b00, a});
	endfunction

	function automatic dcache_pkg::line_t line_value(input logic [27:0] la);
		dcache_pkg::line_t l;
		for (int k = 0; k < `DC_WORDS_PER_LINE; k++) begin
			l[k*`DC_WORD_BITS +: `DC_WORD_BITS] = word_value({la, 2'(k)});
		end
		return l;
	endfunction

	task automatic note_error(input string msg);
		$display("test %0d: %s", test_id, msg);
		errors++;
		test_errs++;
	endtask

	task automatic value_fail(input string sig, input logic [127:0] got, input logic [127:0] exp);
		$display("FAIL test %0d %s got %0h exp %0h", test_id, sig, got, exp);
		errors++;
		test_errs++;
	endtask

	// ------------------------------
	// end of one request
	// ------------------------------
	task automatic finish_test();
		logic [29:0]       a;
		dcache_pkg::word_t want;
		a = proc_addr;
		if (exp_hit == seen_stall) begin
			note_error(exp_hit ? "expected a hit but the request stalled"
			                   : "expected a miss but the request did not stall");
		end
		if (proc_read && exp_rd_kind != 2'd0) begin
			want = (exp_rd_kind == 2'd1) ? word_value(a) : exp_rdata;
			if (proc_rdata !== want) begin
				value_fail("proc_rdata", 128'(proc_rdata), 128'(want));
			end
		end
		if (exp_wb_valid) begin
			if (wb_cnt != 1) begin
				note_error($sformatf("expected one writeback, saw %0d", wb_cnt));
			end else if (wb_addr != exp_wb_addr) begin
				value_fail("mem_addr", 128'(wb_addr), 128'(exp_wb_addr));
			end
		end else if (wb_cnt != 0) begin
			note_error("writeback seen where none was expected");
		end
		if (proc_write) begin
			shadow[a] = proc_wdata;    // lands in the DUT on this same edge
		end
		tests_done++;
		$display("test %0d %s %h %s", test_id, proc_write ? "W" : "R", a,
		         (test_errs == 0) ? "ok" : "failed");
		seen_stall = 1'b0;
		wb_cnt     = 0;
		test_errs  = 0;
	endtask

	always @(posedge clk) begin
		logic [27:0] req_line;
		req_line = proc_addr[29:2];
		if (proc_reset) begin
			reset_seen = 1'b1;
			errors     = 0;
			tests_done = 0;
			seen_stall = 1'b0;
			wb_cnt     = 0;
			test_errs  = 0;
			prev_rd    = 1'b0;
			prev_wr    = 1'b0;
			prev_ready = 1'b0;
		end else begin
			if (reset_seen) begin
				reset_seen = 1'b0;
				if (proc_stall || mem_read || mem_write) begin
					note_error("proc_stall, mem_read or mem_write not low after reset");
				end
			end
			// ------------------------------
			// memory protocol
			// ------------------------------
			if (mem_read && mem_write) begin
				note_error("mem_read and mem_write high together");
			end
			if ((prev_rd || prev_wr) && !prev_ready) begin
				if (mem_read != prev_rd || mem_write != prev_wr) begin
					note_error("memory strobe dropped or changed before mem_ready");
				end else if (mem_addr != prev_addr) begin
					value_fail("mem_addr", 128'(mem_addr), 128'(prev_addr));
				end else if (prev_wr && mem_wdata != prev_wdata) begin
					value_fail("mem_wdata", mem_wdata, prev_wdata);
				end
			end
			prev_rd    = mem_read;
			prev_wr    = mem_write;
			prev_ready = mem_ready;
			prev_addr  = mem_addr;
			prev_wdata = mem_wdata;
			if (proc_read || proc_write) begin
				if (proc_stall) begin
					seen_stall = 1'b1;
				end
				if (mem_read && mem_addr != req_line) begin
					value_fail("mem_addr", 128'(mem_addr), 128'(req_line));
				end
				if (mem_read && exp_wb_valid && wb_cnt == 0) begin
					note_error("line fetched before the dirty victim was written back");
				end
				if (mem_write && mem_ready) begin
					wb_cnt++;
					wb_addr = mem_addr;
					if (mem_wdata !== line_value(mem_addr)) begin
						value_fail("mem_wdata", mem_wdata, line_value(mem_addr));
					end
				end
				if (!proc_stall) begin
					if (mem_read || mem_write) begin
						note_error("memory strobe high while the request completes");
					end
					finish_test();
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: dcache.sv
// two way write-back data cache
`default_nettype none
`timescale 1ns/1ps

`include "dcache_settings.svh"

module dcache (
	input  logic                   clk,
	input  logic                   proc_reset,
	// processor side
	input  logic                   proc_read,
	input  logic                   proc_write,
	input  dcache_pkg::proc_addr_t proc_addr,
	input  dcache_pkg::word_t      proc_wdata,
	output dcache_pkg::word_t      proc_rdata,
	output logic                   proc_stall,
	// memory side
	output logic                   mem_read,
	output logic                   mem_write,
	output dcache_pkg::mem_addr_t  mem_addr,
	output dcache_pkg::line_t      mem_wdata,
	input  dcache_pkg::line_t      mem_rdata,
	input  logic                   mem_ready
);

	dcache_pkg::way_cmd_t                  way_cmd;
	dcache_pkg::way_view_t [`DC_WAYS-1:0] views;
	dcache_pkg::way_idx_t                  hit_way;
	dcache_pkg::way_idx_t                  victim_way;
	dcache_pkg::mem_addr_t                 victim_addr;
	dcache_pkg::mem_addr_t                 req_addr;
	logic                                  any_hit;
	logic                                  victim_dirty;
	logic                                  addr_sel_victim;

	// ------------------------------
	// controller
	// ------------------------------
	cache_ctrl ctrl_inst (
		.clk             (clk),
		.proc_reset      (proc_reset),
		.proc_read       (proc_read),
		.proc_write      (proc_write),
		.proc_addr       (proc_addr),
		.proc_wdata      (proc_wdata),
		.mem_rdata       (mem_rdata),
		.mem_ready       (mem_ready),
		.any_hit         (any_hit),
		.hit_way         (hit_way),
		.victim_dirty    (victim_dirty),
		.way_cmd         (way_cmd),
		.victim_way      (victim_way),
		.proc_stall      (proc_stall),
		.mem_read        (mem_read),
		.mem_write       (mem_write),
		.addr_sel_victim (addr_sel_victim)
	);

	// ------------------------------
	// ways
	// ------------------------------
	for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
		cache_way #(
			.WAY_INDEX (w)
		) way_inst (
			.clk        (clk),
			.proc_reset (proc_reset),
			.proc_addr  (proc_addr),
			.way_cmd    (way_cmd),
			.fill_line  (mem_rdata),
			.view       (views[w])
		);
	end

	way_select sel_inst (
		.proc_addr    (proc_addr),
		.views        (views),
		.victim_way   (victim_way),
		.any_hit      (any_hit),
		.hit_way      (hit_way),
		.victim_dirty (victim_dirty),
		.rd_word      (proc_rdata),
		.victim_line  (mem_wdata),
		.victim_addr  (victim_addr)
	);

	// write back goes to the victim line, fills to the requested one
	assign req_addr = '{tag: proc_addr.tag, set: proc_addr.set};
	assign mem_addr = addr_sel_victim ? victim_addr : req_addr;

endmodule

`default_nettype wire

// File: cache_ctrl.sv
// data cache controller
`default_nettype none
`timescale 1ns/1ps

`include "dcache_settings.svh"

module cache_ctrl (
	input  logic                   clk,
	input  logic                   proc_reset,
	input  logic                   proc_read,
	input  logic                   proc_write,
	input  dcache_pkg::proc_addr_t proc_addr,
	input  dcache_pkg::word_t      proc_wdata,
	input  dcache_pkg::line_t      mem_rdata,
	input  logic                   mem_ready,
	input  logic                   any_hit,
	input  dcache_pkg::way_idx_t   hit_way,
	input  logic                   victim_dirty,
	output dcache_pkg::way_cmd_t   way_cmd,
	output dcache_pkg::way_idx_t   victim_way,
	output logic                   proc_stall,
	output logic                   mem_read,
	output logic                   mem_write,
	output logic                   addr_sel_victim
);

	dcache_pkg::cc_state_t                state;
	dcache_pkg::cc_state_t                state_nxt;
	dcache_pkg::way_idx_t [`DC_SETS-1:0] lru_way;    // least recently filled way per set
	logic                                 req;
	logic                                 miss;

	assign req        = proc_read | proc_write;
	assign miss       = req & ~any_hit;
	assign victim_way = lru_way[proc_addr.set];

	// ------------------------------
	// next state
	// ------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			dcache_pkg::CC_IDLE: begin
				state_nxt = dcache_pkg::CC_COMPARE;
			end
			dcache_pkg::CC_COMPARE: begin
				if (miss) begin
					state_nxt = victim_dirty ? dcache_pkg::CC_WRITE_BACK
					                         : dcache_pkg::CC_ALLOCATE;
				end
			end
			dcache_pkg::CC_WRITE_BACK: begin
				if (mem_ready) begin
					state_nxt = dcache_pkg::CC_ALLOCATE;
				end
			end
			dcache_pkg::CC_ALLOCATE: begin
				if (mem_ready) begin
					state_nxt = dcache_pkg::CC_COMPARE;    // retry, hits next cycle
				end
			end
			default: begin
				state_nxt = dcache_pkg::CC_IDLE;
			end
		endcase
	end

	// ------------------------------
	// outputs and way commands
	// ------------------------------
	always_comb begin
		way_cmd         = '0;
		way_cmd.wdata   = proc_wdata;
		proc_stall      = 1'b0;
		mem_read        = 1'b0;
		mem_write       = 1'b0;
		addr_sel_victim = 1'b0;
		case (state)
			dcache_pkg::CC_IDLE: begin
				proc_stall = req;    // hold off anything arriving right after reset
			end
			dcache_pkg::CC_COMPARE: begin
				proc_stall         = miss;
				way_cmd.write_word = proc_write & any_hit;
				way_cmd.way        = hit_way;
			end
			dcache_pkg::CC_WRITE_BACK: begin
				proc_stall      = 1'b1;
				mem_write       = 1'b1;
				addr_sel_victim = 1'b1;
				way_cmd.clean   = mem_ready;
				way_cmd.way     = victim_way;
			end
			dcache_pkg::CC_ALLOCATE: begin
				proc_stall   = 1'b1;
				mem_read     = 1'b1;
				way_cmd.fill = mem_ready;    // line lands on the ready edge
				way_cmd.way  = victim_way;
			end
			default: begin
				proc_stall = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state   <= dcache_pkg::CC_IDLE;
			lru_way <= '0;
		end else begin
			state <= state_nxt;
			if (way_cmd.fill) begin
				lru_way[proc_addr.set] <= ~victim_way;    // filled way is now most recent
			end
		end
	end

	// ------------------------------
	// memory protocol
	// ------------------------------
	a_strobe_excl: assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_read && mem_write))
		else $error("mem_read and mem_write high together");

	a_read_held: assert property (@(posedge clk) disable iff (proc_reset)
		mem_read && !mem_ready |=> mem_read)
		else $error("mem_read dropped before mem_ready");

	a_write_held: assert property (@(posedge clk) disable iff (proc_reset)
		mem_write && !mem_ready |=> mem_write)
		else $error("mem_write dropped before mem_ready");

	// the memory must hand back real data on the fill edge
	a_fill_known: assert property (@(posedge clk) disable iff (proc_reset)
		way_cmd.fill |-> !$isunknown(mem_rdata))
		else $error("fill with unknown mem_rdata");

endmodule

`default_nettype wire

// File: way_select.sv
// way hit merge and victim select
`default_nettype none
`timescale 1ns/1ps

`include "dcache_settings.svh"

module way_select (
	input  dcache_pkg::proc_addr_t                 proc_addr,
	input  dcache_pkg::way_view_t [`DC_WAYS-1:0] views,
	input  dcache_pkg::way_idx_t                   victim_way,
	output logic                                   any_hit,
	output dcache_pkg::way_idx_t                   hit_way,
	output logic                                   victim_dirty,
	output dcache_pkg::word_t                      rd_word,
	output dcache_pkg::line_t                      victim_line,
	output dcache_pkg::mem_addr_t                  victim_addr
);

	logic [`DC_WAYS-1:0]   hits;
	dcache_pkg::line_t     hit_line;
	dcache_pkg::way_view_t victim;

	// ------------------------------
	// hit side
	// ------------------------------
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < `DC_WAYS; w++) begin
			hits[w] = views[w].hit;
			if (views[w].hit) begin
				hit_way = dcache_pkg::way_idx_t'(w);
			end
		end
	end

	assign any_hit  = |hits;
	assign hit_line = views[hit_way].line;

	always_comb begin
		rd_word = '0;    // zero on a miss
		for (int k = 0; k < `DC_WORDS_PER_LINE; k++) begin
			if (any_hit && proc_addr.ofs == `DC_OFS_BITS'(k)) begin
				rd_word = hit_line[k*`DC_WORD_BITS +: `DC_WORD_BITS];
			end
		end
	end

	// ------------------------------
	// victim side
	// ------------------------------
	assign victim       = views[victim_way];
	assign victim_dirty = victim.dirty;
	assign victim_line  = victim.line;
	assign victim_addr  = '{tag: victim.tag, set: proc_addr.set};    // victim keeps its own tag

	// fills only happen on a miss, so a tag lives in one way per set at most
	always_comb begin
		a_one_hit: assert final ($onehot0(hits))
			else $error("more than one way hits in set %0d", proc_addr.set);
	end

endmodule

`default_nettype wire

// File: cache_way.sv
// one cache way
`default_nettype none
`timescale 1ns/1ps

`include "dcache_settings.svh"

module cache_way #(
	parameter int WAY_INDEX = 0
) (
	input  logic                   clk,
	input  logic                   proc_reset,
	input  dcache_pkg::proc_addr_t proc_addr,
	input  dcache_pkg::way_cmd_t   way_cmd,
	input  dcache_pkg::line_t      fill_line,
	output dcache_pkg::way_view_t  view
);

	dcache_pkg::way_meta_t meta [`DC_SETS];
	dcache_pkg::line_t     data [`DC_SETS];
	dcache_pkg::way_meta_t cur_meta;
	logic                  sel;

	assign sel      = (way_cmd.way == dcache_pkg::way_idx_t'(WAY_INDEX));
	assign cur_meta = meta[proc_addr.set];

	// ------------------------------
	// lookup for the addressed set
	// ------------------------------
	assign view.hit   = cur_meta.valid && (cur_meta.tag == proc_addr.tag);
	assign view.dirty = cur_meta.dirty;
	assign view.tag   = cur_meta.tag;
	assign view.line  = data[proc_addr.set];

	// ------------------------------
	// state bits
	// ------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int s = 0; s < `DC_SETS; s++) begin
				meta[s] <= '0;    // all lines invalid
			end
		end else if (sel) begin
			if (way_cmd.fill) begin
				meta[proc_addr.set] <= '{valid: 1'b1, dirty: 1'b0, tag: proc_addr.tag};
			end else if (way_cmd.write_word) begin
				meta[proc_addr.set].dirty <= 1'b1;
			end else if (way_cmd.clean) begin
				meta[proc_addr.set].dirty <= 1'b0;    // line now matches memory
			end
		end
	end

	// line storage
	always_ff @(posedge clk) begin
		if (sel && way_cmd.fill) begin
			data[proc_addr.set] <= fill_line;
		end else if (sel && way_cmd.write_word) begin
			for (int k = 0; k < `DC_WORDS_PER_LINE; k++) begin
				if (proc_addr.ofs == `DC_OFS_BITS'(k)) begin
					data[proc_addr.set][k*`DC_WORD_BITS +: `DC_WORD_BITS] <= way_cmd.wdata;
				end
			end
		end
	end

	// controller must only send word writes to the way that hit
	a_write_on_hit: assert property (@(posedge clk) disable iff (proc_reset)
		sel && way_cmd.write_word |-> view.hit)
		else $error("word write to way %0d without a matching valid line", WAY_INDEX);

endmodule

`default_nettype wire

// File: dcache_pkg.sv
// data cache shared types
`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

	typedef logic [`DC_WORD_BITS-1:0]     word_t;
	typedef logic [`DC_LINE_BITS-1:0]     line_t;
	typedef logic [$clog2(`DC_WAYS)-1:0] way_idx_t;

	// processor word address, tag width follows from the address split
	typedef struct packed {
		logic [`DC_ADDR_BITS-`DC_SET_BITS-`DC_OFS_BITS-1:0] tag;
		logic [`DC_SET_BITS-1:0]                            set;
		logic [`DC_OFS_BITS-1:0]                            ofs;
	} proc_addr_t;

	typedef struct packed {
		logic [`DC_TAG_BITS-1:0] tag;
		logic [`DC_SET_BITS-1:0] set;
	} mem_addr_t;    // line address toward memory

	typedef struct packed {
		logic                    valid;
		logic                    dirty;
		logic [`DC_TAG_BITS-1:0] tag;
	} way_meta_t;

	// one command for all ways, only the addressed way acts on it
	typedef struct packed {
		logic     fill;
		logic     write_word;
		logic     clean;
		way_idx_t way;
		word_t    wdata;
	} way_cmd_t;

	typedef struct packed {
		logic                    hit;
		logic                    dirty;
		logic [`DC_TAG_BITS-1:0] tag;
		line_t                   line;
	} way_view_t;

	typedef enum logic [1:0] {
		CC_IDLE,
		CC_COMPARE,
		CC_WRITE_BACK,
		CC_ALLOCATE
	} cc_state_t;

endpackage

`default_nettype wire

// File: dcache_settings.svh
// data cache geometry
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// ------------------------------
// organisation
// ------------------------------
`define DC_WAYS           2
`define DC_SETS           4

// ------------------------------
// widths
// ------------------------------
`define DC_WORD_BITS      32
`define DC_LINE_BITS      128
`define DC_WORDS_PER_LINE 4
`define DC_ADDR_BITS      30    // processor side is word addressed
`define DC_TAG_BITS       26
`define DC_SET_BITS       2
`define DC_OFS_BITS       2     // word within line

`endif
